// ==== files.f ====
+incdir+src
src/rv_pkg.sv
src/rv_fetch.sv
src/rv_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_mem_wb.sv
src/rv_core.sv
verif/rv_core_checker.sv
verif/rv_core_tb.sv

// ==== src/rv_consts.svh ====
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

`define RV_XLEN      32
`define RV_REGS_AW   5
`define RV_RESET_PC  32'h0000_0000
`define RV_NOP       32'h0000_0013    // ADDI x0,x0,0

`define RV_OP_RTYPE  7'b0110011
`define RV_OP_ITYPE  7'b0010011
`define RV_OP_LOAD   7'b0000011
`define RV_OP_STORE  7'b0100011
`define RV_OP_BRANCH 7'b1100011

`define RV_F3_ADD    3'b000           // ADD, SUB and ADDI
`define RV_F3_SLT    3'b010
`define RV_F3_OR     3'b110
`define RV_F3_AND    3'b111
`define RV_F3_LW     3'b010
`define RV_F3_SW     3'b010
`define RV_F3_BEQ    3'b000
`define RV_F7_BASE   7'b0000000
`define RV_F7_SUB    7'b0100000

`endif

// ==== src/rv_core.sv ====
module rv_core (
   input  logic          clk_i,
   input  logic          arst_n_i,
   input  rv_pkg::word_t inst_i,
   output rv_pkg::word_t inst_addr_o,
   output logic          inst_ce_o,
   input  rv_pkg::word_t data_i,
   output rv_pkg::word_t data_addr_o,
   output rv_pkg::word_t data_o,
   output logic          data_ce_o,
   output logic          data_we_o
);

   logic              stall;
   rv_pkg::redirect_t redirect;
   rv_pkg::word_t     if_inst;
   rv_pkg::word_t     if_pc;
   rv_pkg::reg_addr_t rs1_addr;
   rv_pkg::reg_addr_t rs2_addr;
   rv_pkg::word_t     rs1_data;
   rv_pkg::word_t     rs2_data;
   rv_pkg::id_ex_t    id_ex;
   rv_pkg::ex_mem_t   ex_mem;
   rv_pkg::wb_t       wb;

   rv_fetch rv_fetch_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .stall_i     (stall),
      .redirect_i  (redirect),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .if_inst_o   (if_inst),
      .if_pc_o     (if_pc)
   );

   rv_decode rv_decode_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .if_inst_i   (if_inst),
      .if_pc_i     (if_pc),
      .rs1_addr_o  (rs1_addr),
      .rs2_addr_o  (rs2_addr),
      .rs1_data_i  (rs1_data),
      .rs2_data_i  (rs2_data),
      .redirect_i  (redirect),
      .stall_o     (stall),
      .id_ex_o     (id_ex)
   );

   rv_regfile rv_regfile_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .rs1_addr_i  (rs1_addr),
      .rs2_addr_i  (rs2_addr),
      .rs1_data_o  (rs1_data),
      .rs2_data_o  (rs2_data),
      .wb_i        (wb)
   );

   rv_execute rv_execute_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .id_ex_i     (id_ex),
      .wb_i        (wb),
      .redirect_o  (redirect),
      .ex_mem_o    (ex_mem)
   );

   rv_mem_wb rv_mem_wb_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .ex_mem_i    (ex_mem),
      .data_i      (data_i),
      .data_addr_o (data_addr_o),
      .data_o      (data_o),
      .data_ce_o   (data_ce_o),
      .data_we_o   (data_we_o),
      .wb_o        (wb)
   );

endmodule

// ==== src/rv_decode.sv ====
`include "rv_consts.svh"

module rv_decode (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  rv_pkg::word_t     if_inst_i,
   input  rv_pkg::word_t     if_pc_i,
   output rv_pkg::reg_addr_t rs1_addr_o,
   output rv_pkg::reg_addr_t rs2_addr_o,
   input  rv_pkg::word_t     rs1_data_i,
   input  rv_pkg::word_t     rs2_data_i,
   input  rv_pkg::redirect_t redirect_i,
   output logic              stall_o,
   output rv_pkg::id_ex_t    id_ex_o
);

   logic [6:0]      opcode;
   logic [2:0]      funct3;
   logic [6:0]      funct7;
   logic            valid;
   logic            use_rs1;
   logic            use_rs2;
   rv_pkg::ctrl_t   ctrl;
   rv_pkg::alu_op_e aluop;
   rv_pkg::word_t   imm;
   rv_pkg::id_ex_t  id_ex_q;

   assign opcode     = if_inst_i[6:0];
   assign funct3     = if_inst_i[14:12];
   assign funct7     = if_inst_i[31:25];
   assign rs1_addr_o = if_inst_i[19:15];
   assign rs2_addr_o = if_inst_i[24:20];

   always_comb begin
      valid   = 1'b0;
      ctrl    = '0;
      aluop   = rv_pkg::ALU_ADD;
      imm     = {{20{if_inst_i[31]}}, if_inst_i[31:20]};             // I format
      use_rs1 = 1'b1;
      use_rs2 = 1'b0;
      case (opcode)
         `RV_OP_RTYPE: begin
            valid         = 1'b1;
            ctrl.regwrite = 1'b1;
            use_rs2       = 1'b1;
            case ({funct7, funct3})
               {`RV_F7_BASE, `RV_F3_ADD}: aluop = rv_pkg::ALU_ADD;
               {`RV_F7_SUB,  `RV_F3_ADD}: aluop = rv_pkg::ALU_SUB;
               {`RV_F7_BASE, `RV_F3_AND}: aluop = rv_pkg::ALU_AND;
               {`RV_F7_BASE, `RV_F3_OR }: aluop = rv_pkg::ALU_OR;
               {`RV_F7_BASE, `RV_F3_SLT}: aluop = rv_pkg::ALU_SLT;
               default:                   valid = 1'b0;
            endcase
         end
         `RV_OP_ITYPE: begin
            valid         = (funct3 == `RV_F3_ADD);                 // ADDI only
            ctrl.regwrite = 1'b1;
            ctrl.alusrc   = 1'b1;
         end
         `RV_OP_LOAD: begin
            valid         = (funct3 == `RV_F3_LW);
            ctrl.regwrite = 1'b1;
            ctrl.memread  = 1'b1;
            ctrl.alusrc   = 1'b1;
         end
         `RV_OP_STORE: begin
            valid         = (funct3 == `RV_F3_SW);
            ctrl.memwrite = 1'b1;
            ctrl.alusrc   = 1'b1;
            use_rs2       = 1'b1;
            imm = {{20{if_inst_i[31]}}, if_inst_i[31:25], if_inst_i[11:7]};
         end
         `RV_OP_BRANCH: begin
            valid       = (funct3 == `RV_F3_BEQ);
            ctrl.branch = 1'b1;
            use_rs2     = 1'b1;
            imm = {{19{if_inst_i[31]}}, if_inst_i[31], if_inst_i[7],
                   if_inst_i[30:25], if_inst_i[11:8], 1'b0};
         end
         default: ;
      endcase
      if (!valid) begin                                              // Unsupported is a no-op
         ctrl    = '0;
         use_rs1 = 1'b0;
         use_rs2 = 1'b0;
      end
   end

   // Load in ID/EX feeding the instruction in decode
   assign stall_o = id_ex_q.ctrl.memread && (id_ex_q.rd != '0) &&
                    ((use_rs1 && rs1_addr_o == id_ex_q.rd) ||
                     (use_rs2 && rs2_addr_o == id_ex_q.rd));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         id_ex_q <= '0;
      end else begin
         id_ex_q.ctrl     <= (stall_o || redirect_i.taken) ? '0 : ctrl;  // Bubble
         id_ex_q.aluop    <= aluop;
         id_ex_q.pc       <= if_pc_i;
         id_ex_q.imm      <= imm;
         id_ex_q.rs1      <= rs1_addr_o;
         id_ex_q.rs2      <= rs2_addr_o;
         id_ex_q.rd       <= if_inst_i[11:7];
         id_ex_q.rs1_data <= rs1_data_i;
         id_ex_q.rs2_data <= rs2_data_i;
      end
   end

   assign id_ex_o = id_ex_q;

endmodule

// ==== src/rv_execute.sv ====
module rv_execute (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  rv_pkg::id_ex_t    id_ex_i,
   input  rv_pkg::wb_t       wb_i,
   output rv_pkg::redirect_t redirect_o,
   output rv_pkg::ex_mem_t   ex_mem_o
);

   rv_pkg::ex_mem_t ex_mem_q;
   rv_pkg::word_t   op_a;
   rv_pkg::word_t   op_b;
   rv_pkg::word_t   alu_b;
   rv_pkg::word_t   alu_result;

   // Youngest producer wins; loads in EX/MEM are covered by the stall
   function automatic rv_pkg::word_t fwd(input rv_pkg::reg_addr_t rs,
                                         input rv_pkg::word_t     reg_val);
      rv_pkg::word_t val;
      if (rs == '0)
         val = reg_val;
      else if (ex_mem_q.ctrl.regwrite && !ex_mem_q.ctrl.memread && ex_mem_q.rd == rs)
         val = ex_mem_q.alu_result;
      else if (wb_i.regwrite && wb_i.rd == rs)
         val = wb_i.data;
      else
         val = reg_val;
      return val;
   endfunction

   always_comb begin
      op_a  = fwd(id_ex_i.rs1, id_ex_i.rs1_data);
      op_b  = fwd(id_ex_i.rs2, id_ex_i.rs2_data);
      alu_b = id_ex_i.ctrl.alusrc ? id_ex_i.imm : op_b;
   end

   always_comb begin
      case (id_ex_i.aluop)
         rv_pkg::ALU_SUB: alu_result = op_a - alu_b;
         rv_pkg::ALU_AND: alu_result = op_a & alu_b;
         rv_pkg::ALU_OR:  alu_result = op_a | alu_b;
         rv_pkg::ALU_SLT: alu_result = {31'd0, $signed(op_a) < $signed(alu_b)};
         default:         alu_result = op_a + alu_b;
      endcase
   end

   // BEQ only
   assign redirect_o.taken  = id_ex_i.ctrl.branch && (op_a == op_b);
   assign redirect_o.target = id_ex_i.pc + id_ex_i.imm;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ex_mem_q <= '0;
      end else begin
         ex_mem_q.ctrl       <= id_ex_i.ctrl;      // A bubble stays a bubble
         ex_mem_q.rd         <= id_ex_i.rd;
         ex_mem_q.alu_result <= alu_result;
         ex_mem_q.store_data <= op_b;              // Forwarded store value
      end
   end

   assign ex_mem_o = ex_mem_q;

endmodule

// ==== src/rv_fetch.sv ====
`include "rv_consts.svh"

module rv_fetch (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  logic              stall_i,
   input  rv_pkg::redirect_t redirect_i,
   input  rv_pkg::word_t     inst_i,
   output rv_pkg::word_t     inst_addr_o,
   output logic              inst_ce_o,
   output rv_pkg::word_t     if_inst_o,
   output rv_pkg::word_t     if_pc_o
);

   rv_pkg::word_t pc_q;
   rv_pkg::word_t if_inst_q;
   rv_pkg::word_t if_pc_q;
   logic          ce_q;         // Fetch enabled one clock after reset

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q      <= `RV_RESET_PC;
         ce_q      <= 1'b0;
         if_inst_q <= `RV_NOP;
      end else begin
         ce_q <= 1'b1;
         if (redirect_i.taken) begin
            pc_q      <= redirect_i.target;
            if_inst_q <= `RV_NOP;          // Squash the wrong-path fetch
         end else if (ce_q && !stall_i) begin
            pc_q      <= pc_q + 32'd4;
            if_inst_q <= inst_i;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ce_q && !stall_i)
         if_pc_q <= pc_q;
   end

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ce_q;
   assign if_inst_o   = if_inst_q;
   assign if_pc_o     = if_pc_q;

endmodule

// ==== src/rv_mem_wb.sv ====
module rv_mem_wb (
   input  logic            clk_i,
   input  logic            arst_n_i,
   input  rv_pkg::ex_mem_t ex_mem_i,
   input  rv_pkg::word_t   data_i,
   output rv_pkg::word_t   data_addr_o,
   output rv_pkg::word_t   data_o,
   output logic            data_ce_o,
   output logic            data_we_o,
   output rv_pkg::wb_t     wb_o
);

   rv_pkg::wb_t wb_q;

   // Combinational memory, load data returns this cycle
   assign data_addr_o = ex_mem_i.alu_result;
   assign data_o      = ex_mem_i.store_data;
   assign data_ce_o   = ex_mem_i.ctrl.memread || ex_mem_i.ctrl.memwrite;
   assign data_we_o   = ex_mem_i.ctrl.memwrite;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wb_q <= '0;
      end else begin
         wb_q.regwrite <= ex_mem_i.ctrl.regwrite;
         wb_q.rd       <= ex_mem_i.rd;
         wb_q.data     <= ex_mem_i.ctrl.memread ? data_i : ex_mem_i.alu_result;
      end
   end

   assign wb_o = wb_q;

endmodule

// ==== src/rv_pkg.sv ====
`include "rv_consts.svh"

package rv_pkg;

   typedef logic [`RV_XLEN-1:0]    word_t;      // Data, address or instruction
   typedef logic [`RV_REGS_AW-1:0] reg_addr_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_e;

   // All zero is a bubble
   typedef struct packed {
      logic regwrite;
      logic memread;
      logic memwrite;
      logic alusrc;    // Immediate as second operand
      logic branch;
   } ctrl_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } redirect_t;

   typedef struct packed {
      ctrl_t     ctrl;
      alu_op_e   aluop;
      word_t     pc;
      word_t     imm;
      reg_addr_t rs1;
      reg_addr_t rs2;
      reg_addr_t rd;
      word_t     rs1_data;
      word_t     rs2_data;
   } id_ex_t;

   typedef struct packed {
      ctrl_t     ctrl;
      reg_addr_t rd;
      word_t     alu_result;  // Also the data address
      word_t     store_data;
   } ex_mem_t;

   typedef struct packed {
      logic      regwrite;
      reg_addr_t rd;
      word_t     data;
   } wb_t;

endpackage

// ==== src/rv_regfile.sv ====
module rv_regfile (
   input  logic              clk_i,
   input  logic              arst_n_i,
   input  rv_pkg::reg_addr_t rs1_addr_i,
   input  rv_pkg::reg_addr_t rs2_addr_i,
   output rv_pkg::word_t     rs1_data_o,
   output rv_pkg::word_t     rs2_data_o,
   input  rv_pkg::wb_t       wb_i
);

   rv_pkg::word_t regs_q [1:31];   // No storage for x0

   function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
      rv_pkg::word_t val;
      if (addr == '0)
         val = '0;
      else if (wb_i.regwrite && wb_i.rd == addr)
         val = wb_i.data;           // Write-through bypass
      else
         val = regs_q[addr];
      return val;
   endfunction

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         for (int i = 1; i < 32; i++)
            regs_q[i] <= '0;
      end else if (wb_i.regwrite && wb_i.rd != '0) begin
         regs_q[wb_i.rd] <= wb_i.data;
      end
   end

   always_comb begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
   end

endmodule

// ==== verif/rv_core_checker.sv ====
module rv_core_checker (
   input logic              clk_i,
   input logic              arst_n_i,
   input logic              data_ce_i,
   input logic              data_we_i,
   input logic              stall_i,
   input rv_pkg::reg_addr_t rs1_addr_i,
   input rv_pkg::word_t     rs1_data_i,
   input rv_pkg::reg_addr_t rs2_addr_i,
   input rv_pkg::word_t     rs2_data_i
);

   we_needs_ce: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 data_we_i |-> data_ce_i)
      else $error("data_we_o high without data_ce_o");

   quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> (!data_ce_i && !data_we_i))
      else $error("data access while in reset");

   // Load-use bubble is a single cycle
   single_stall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                  stall_i |=> !stall_i)
      else $error("stall held for two cycles");

   x0_rs1_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 (rs1_addr_i == '0) |-> (rs1_data_i == '0))
      else $error("x0 read nonzero on port 1");

   x0_rs2_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                                 (rs2_addr_i == '0) |-> (rs2_data_i == '0))
      else $error("x0 read nonzero on port 2");

endmodule

// ==== verif/rv_core_tb.sv ====
`include "rv_consts.svh"

module rv_core_tb;

   localparam int PROG_LEN       = 60;
   localparam int RAND_LEN       = PROG_LEN - 8;      // Seven tail stores and the self-loop
   localparam int TIMEOUT_CYCLES = 4 * PROG_LEN + 100;
   localparam int DRAIN_CYCLES   = 20;               // Quiet time for stray stores

   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_OR   = 3;
   localparam int K_SLT  = 4;
   localparam int K_ADDI = 5;
   localparam int K_LW   = 6;
   localparam int K_SW   = 7;
   localparam int K_BEQ  = 8;

   logic              clk_i = 1'b0;
   logic              arst_n_i;
   rv_pkg::word_t     inst_i;
   rv_pkg::word_t     inst_addr_o;
   logic              inst_ce_o;
   rv_pkg::word_t     data_i;
   rv_pkg::word_t     data_addr_o;
   rv_pkg::word_t     data_o;
   logic              data_ce_o;
   logic              data_we_o;

   rv_pkg::word_t     imem [0:255];
   rv_pkg::word_t     dmem [0:63];
   int                kind_a [0:PROG_LEN-1];
   rv_pkg::reg_addr_t rd_a [0:PROG_LEN-1];
   rv_pkg::reg_addr_t rs1_a [0:PROG_LEN-1];
   rv_pkg::reg_addr_t rs2_a [0:PROG_LEN-1];
   rv_pkg::word_t     imm_a [0:PROG_LEN-1];
   rv_pkg::word_t     exp_addr [$];                  // Expected stores in program order
   rv_pkg::word_t     exp_data [$];
   int                cycle_count = 0;
   logic              fetch_seen = 1'b0;
   logic              ce_exp = 1'b0;                 // Fetch expected from here on

   assign inst_i = imem[inst_addr_o[9:2]];           // Both memories answer at once
   assign data_i = dmem[data_addr_o[7:2]];

   rv_core rv_core_inst (
      .clk_i       (clk_i),
      .arst_n_i    (arst_n_i),
      .inst_i      (inst_i),
      .inst_addr_o (inst_addr_o),
      .inst_ce_o   (inst_ce_o),
      .data_i      (data_i),
      .data_addr_o (data_addr_o),
      .data_o      (data_o),
      .data_ce_o   (data_ce_o),
      .data_we_o   (data_we_o)
   );

   bind rv_core rv_core_checker rv_core_checker_inst (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .data_ce_i  (data_ce_o),
      .data_we_i  (data_we_o),
      .stall_i    (stall),
      .rs1_addr_i (rs1_addr),
      .rs1_data_i (rs1_data),
      .rs2_addr_i (rs2_addr),
      .rs2_data_i (rs2_data)
   );

   task automatic fail_run();
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input rv_pkg::word_t got,
                             input rv_pkg::word_t exp);
      if (got !== exp) begin
         $display("ERROR: %s got 0x%08h, expected 0x%08h", name, got, exp);
         fail_run();
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("ERROR: %s got 0x%h, expected 0x%h", name, got, exp);
         fail_run();
      end
   endtask

   function automatic rv_pkg::word_t encode_inst(input int k, input rv_pkg::reg_addr_t rd,
                                                 input rv_pkg::reg_addr_t rs1,
                                                 input rv_pkg::reg_addr_t rs2,
                                                 input rv_pkg::word_t imm);
      rv_pkg::word_t w;
      case (k)
         K_ADD:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_ADD, rd, `RV_OP_RTYPE};
         K_SUB:   w = {`RV_F7_SUB, rs2, rs1, `RV_F3_ADD, rd, `RV_OP_RTYPE};
         K_AND:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_AND, rd, `RV_OP_RTYPE};
         K_OR:    w = {`RV_F7_BASE, rs2, rs1, `RV_F3_OR, rd, `RV_OP_RTYPE};
         K_SLT:   w = {`RV_F7_BASE, rs2, rs1, `RV_F3_SLT, rd, `RV_OP_RTYPE};
         K_ADDI:  w = {imm[11:0], rs1, `RV_F3_ADD, rd, `RV_OP_ITYPE};
         K_LW:    w = {imm[11:0], rs1, `RV_F3_LW, rd, `RV_OP_LOAD};
         K_SW:    w = {imm[11:5], rs2, rs1, `RV_F3_SW, imm[4:0], `RV_OP_STORE};
         default: w = {imm[12], imm[10:5], rs2, rs1, `RV_F3_BEQ, imm[4:1], imm[11],
                       `RV_OP_BRANCH};
      endcase
      return w;
   endfunction

   task automatic place_inst(input int idx, input int k, input int rd, input int rs1,
                             input int rs2, input rv_pkg::word_t imm);
      kind_a[idx] = k;
      rd_a[idx]   = rd[4:0];
      rs1_a[idx]  = rs1[4:0];
      rs2_a[idx]  = rs2[4:0];
      imm_a[idx]  = imm;
      imem[idx]   = encode_inst(k, rd[4:0], rs1[4:0], rs2[4:0], imm);
   endtask

   task automatic build_program();
      int            i;
      int            k;
      logic [11:0]   imm12;
      rv_pkg::word_t imm;
      for (i = 0; i < 256; i++)
         imem[i] = {4'h0, i[7:0], 13'd0, `RV_OP_ITYPE};  // ADDI x0 no-op tagged by address
      for (i = 0; i < 64; i++)
         dmem[i] = $urandom();
      for (i = 0; i < RAND_LEN; i++) begin
         k     = (i % 4 == 3) ? K_SW : $urandom_range(8, 0);
         imm12 = $urandom_range(4095, 0);
         imm   = {{20{imm12[11]}}, imm12};
         if (k == K_LW || k == K_SW)
            imm = $urandom_range(63, 0) * 4;
         else if (k == K_BEQ)
            imm = $urandom_range(4, 2) * 4;            // Forward skip of 2 to 4
         place_inst(i, k, $urandom_range(7, 0),
                    (k == K_LW || k == K_SW) ? 0 : $urandom_range(7, 0),
                    $urandom_range(7, 0), imm);
      end
      for (i = 1; i <= 7; i++)
         place_inst(RAND_LEN + i - 1, K_SW, 0, 0, i, i * 4);
      place_inst(PROG_LEN - 1, K_BEQ, 0, 0, 0, '0);   // Self-loop
   endtask

   task automatic run_model();
      rv_pkg::word_t regs [0:31];
      rv_pkg::word_t mem [0:63];
      rv_pkg::word_t a;
      rv_pkg::word_t b;
      rv_pkg::word_t addr;
      rv_pkg::word_t res;
      int            i;
      int            pc;
      for (i = 0; i < 32; i++)
         regs[i] = '0;
      for (i = 0; i < 64; i++)
         mem[i] = dmem[i];
      pc = 0;
      while (pc != PROG_LEN - 1) begin
         a    = regs[rs1_a[pc]];
         b    = regs[rs2_a[pc]];
         addr = a + imm_a[pc];
         res  = '0;
         case (kind_a[pc])
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI: res = addr;
            K_LW:   res = mem[addr[7:2]];
            K_SW: begin
               mem[addr[7:2]] = b;
               exp_addr.push_back(addr);
               exp_data.push_back(b);
            end
            default: ;
         endcase
         if (kind_a[pc] <= K_LW && rd_a[pc] != 0)
            regs[rd_a[pc]] = res;                    // x0 stays zero
         if (kind_a[pc] == K_BEQ && a == b)
            pc = pc + int'(imm_a[pc] >> 2);
         else
            pc = pc + 1;
      end
   endtask

   initial begin
      forever #10 clk_i = ~clk_i;
   end

   initial begin
      arst_n_i = 1'b0;
      void'($urandom(32'hfd9d572d));
      build_program();
      run_model();
      repeat (8) @(posedge clk_i);
      arst_n_i <= 1'b1;
      while (exp_addr.size() != 0)
         @(posedge clk_i);
      repeat (DRAIN_CYCLES) @(posedge clk_i);
      $display("Everything OK");
      $finish;
   end

   // Fetch starts one clock after reset is released
   always @(posedge clk_i) begin
      if (arst_n_i)
         ce_exp <= 1'b1;
   end

   // Data memory takes the DUT's stores
   always @(posedge clk_i) begin
      if (arst_n_i && data_we_o)
         dmem[data_addr_o[7:2]] <= data_o;
   end

   // Outputs are settled at the falling edge
   always @(negedge clk_i) begin
      check_bit("inst_ce_o", inst_ce_o, ce_exp);
      if (!ce_exp) begin
         check_bit("data_ce_o", data_ce_o, 1'b0);
      end else begin
         if (!fetch_seen) begin
            check_word("inst_addr_o", inst_addr_o, `RV_RESET_PC);
            fetch_seen = 1'b1;
         end
         if (data_we_o) begin
            if (exp_addr.size() == 0) begin
               $display("A store to 0x%08h arrived when no store was expected", data_addr_o);
               fail_run();
            end else begin
               check_word("data_addr_o", data_addr_o, exp_addr.pop_front());
               check_word("data_o", data_o, exp_data.pop_front());
            end
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles with %0d expected stores still missing",
                  cycle_count, exp_addr.size());
         fail_run();
      end
   end

endmodule
